//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/fetch_pkg.sv
      - rtl/fetch_pc_gen.sv
      - rtl/fetch_align.sv
      - rtl/fetch_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_fetch_top.sv

//--- rtl/fetch_align.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_align #(
    parameter int MAX_OUTSTANDING = 2
) (
    input  wire logic             clk_i,
    input  wire logic             rstn_i,

    input  wire logic             redirect_i,
    input  wire logic             req_fire_i,

    input  wire fetch_pkg::addr_t head_pc_i,
    input  wire logic             head_valid_i,
    output logic                  head_pop_o,

    input  wire logic             mem_rsp_valid_i,
    input  wire isa_pkg::instr_t  mem_rsp_data_i,
    output logic                  mem_rsp_ready_o,

    input  wire logic             stall_i,
    output logic                  inst_valid_o,
    output isa_pkg::instr_t       inst_o,
    output fetch_pkg::addr_t      inst_pc_o
);

    import isa_pkg::*;
    import fetch_pkg::*;

    // Headroom for old-path responses piling up over back-to-back redirects
    localparam int CNT_W = $clog2(4 * MAX_OUTSTANDING + 1);

    align_state_e     state_q;
    align_state_e     state_d;
    logic [CNT_W-1:0] pend_q;         // Responses memory still owes us
    logic [CNT_W-1:0] pend_d;
    logic [CNT_W-1:0] drop_q;         // Responses left to throw away in AL_DRAIN
    logic [CNT_W-1:0] drop_d;
    logic             first_q;        // Next word is the first one after reset or redirect
    logic             first_d;

    parcel_t          half_q;
    parcel_t          half_d;
    addr_t            half_pc_q;
    addr_t            half_pc_d;

    logic             inst_valid_q;
    logic             inst_valid_d;
    instr_t           inst_q;
    instr_t           inst_d;
    addr_t            inst_pc_q;
    addr_t            inst_pc_d;

    logic             rsp_ready;
    logic             rsp_fire;
    logic             take_word;      // Accepted word that belongs to the current path

    parcel_t          word_lo;
    parcel_t          word_hi;
    addr_t            word_pc;
    addr_t            hi_pc;
    logic             lo_skip;

    assign word_lo = mem_rsp_data_i[PARCEL_W-1:0];
    assign word_hi = mem_rsp_data_i[INSTR_W-1:PARCEL_W];
    assign word_pc = word_base(head_pc_i);
    assign hi_pc   = upper_parcel(head_pc_i);
    assign lo_skip = first_q && head_pc_i[1];   // Jumped into the middle of this word

    // Old-path responses are taken freely, live ones only when decode can accept
    always_comb begin
        rsp_ready = 1'b0;
        if (redirect_i) begin
            rsp_ready = pend_q != '0;
        end else begin
            unique case (state_q)
                AL_EMPTY: rsp_ready = head_valid_i && !stall_i;
                AL_HALF:  rsp_ready = head_valid_i && !stall_i && !is_compressed(half_q);
                AL_DRAIN: rsp_ready = 1'b1;
                default:  rsp_ready = 1'b0;
            endcase
        end
    end

    assign rsp_fire  = mem_rsp_valid_i && rsp_ready;
    assign take_word = rsp_fire && !redirect_i && (state_q != AL_DRAIN);

    always_comb begin
        state_d      = state_q;
        pend_d       = pend_q;
        drop_d       = drop_q;
        first_d      = first_q;
        half_d       = half_q;
        half_pc_d    = half_pc_q;
        inst_valid_d = stall_i ? inst_valid_q : 1'b0;   // Decode keeps what it sees while stalled
        inst_d       = inst_q;
        inst_pc_d    = inst_pc_q;

        if (req_fire_i) begin
            pend_d = pend_d + 1'b1;
        end
        if (rsp_fire) begin
            pend_d = pend_d - 1'b1;
        end
        if (take_word) begin
            first_d = 1'b0;
        end

        unique case (state_q)
            AL_EMPTY: begin
                if (take_word) begin
                    if (lo_skip) begin
                        if (is_compressed(word_hi)) begin
                            inst_valid_d = 1'b1;
                            inst_d       = zext_parcel(word_hi);
                            inst_pc_d    = hi_pc;
                        end else begin
                            // Only the first half of a 32-bit instruction is here
                            half_d    = word_hi;
                            half_pc_d = hi_pc;
                            state_d   = AL_HALF;
                        end
                    end else if (!is_compressed(word_lo)) begin
                        inst_valid_d = 1'b1;
                        inst_d       = mem_rsp_data_i;
                        inst_pc_d    = word_pc;
                    end else begin
                        inst_valid_d = 1'b1;
                        inst_d       = zext_parcel(word_lo);
                        inst_pc_d    = word_pc;
                        half_d       = word_hi;   // Sorted out next cycle
                        half_pc_d    = hi_pc;
                        state_d      = AL_HALF;
                    end
                end
            end
            AL_HALF: begin
                if (!stall_i && is_compressed(half_q)) begin
                    inst_valid_d = 1'b1;
                    inst_d       = zext_parcel(half_q);
                    inst_pc_d    = half_pc_q;
                    state_d      = AL_EMPTY;
                end else if (take_word) begin
                    // Instruction crosses the word boundary
                    inst_valid_d = 1'b1;
                    inst_d       = {word_lo, half_q};
                    inst_pc_d    = half_pc_q;
                    half_d       = word_hi;
                    half_pc_d    = hi_pc;
                end
            end
            AL_DRAIN: begin
                if (rsp_fire) begin
                    drop_d = drop_q - 1'b1;
                    if (drop_q == CNT_W'(1)) begin
                        state_d = AL_EMPTY;
                    end
                end
            end
            default: state_d = AL_EMPTY;
        endcase

        if (redirect_i) begin
            // Everything still in flight now belongs to the old path
            drop_d       = pend_d;
            state_d      = (pend_d != '0) ? AL_DRAIN : AL_EMPTY;
            first_d      = 1'b1;
            inst_valid_d = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q      <= AL_EMPTY;
            pend_q       <= '0;
            drop_q       <= '0;
            first_q      <= 1'b1;
            inst_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            pend_q       <= pend_d;
            drop_q       <= drop_d;
            first_q      <= first_d;
            inst_valid_q <= inst_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        half_q    <= half_d;
        half_pc_q <= half_pc_d;
        inst_q    <= inst_d;
        inst_pc_q <= inst_pc_d;
    end

    assign head_pop_o      = take_word;
    assign mem_rsp_ready_o = rsp_ready;
    assign inst_valid_o    = inst_valid_q;
    assign inst_o          = inst_q;
    assign inst_pc_o       = inst_pc_q;

endmodule

`default_nettype wire

//--- rtl/fetch_pc_gen.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_gen #(
    parameter int               MAX_OUTSTANDING = 2,
    parameter fetch_pkg::addr_t RESET_PC        = '0
) (
    input  wire logic             clk_i,
    input  wire logic             rstn_i,

    input  wire logic             redirect_i,
    input  wire fetch_pkg::addr_t redirect_pc_i,

    output logic                  mem_req_valid_o,
    output fetch_pkg::addr_t      mem_req_addr_o,
    input  wire logic             mem_req_ready_i,

    output logic                  req_fire_o,
    output fetch_pkg::addr_t      head_pc_o,
    output logic                  head_valid_o,
    input  wire logic             head_pop_i
);

    import fetch_pkg::*;

    localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

    addr_t            pc_q;                        // Next PC to request
    addr_t            pc_queue_q [MAX_OUTSTANDING]; // PCs of requests in flight, oldest first
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             fetch_en_q;                  // Goes high one cycle after reset
    logic             req_fire;

    // Ring pointer step, also for a depth that is not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : p + 1'b1;
    endfunction

    assign mem_req_valid_o = fetch_en_q && (count_q < CNT_W'(MAX_OUTSTANDING));
    assign mem_req_addr_o  = word_base(pc_q);   // Memory only ever sees word addresses
    assign req_fire        = mem_req_valid_o && mem_req_ready_i;
    assign req_fire_o      = req_fire;

    assign head_pc_o    = pc_queue_q[rd_ptr_q];
    assign head_valid_o = count_q != '0;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            fetch_en_q <= 1'b0;
            pc_q       <= RESET_PC;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
        end else begin
            fetch_en_q <= 1'b1;
            if (redirect_i) begin
                // A request firing in this cycle is still on the old path
                pc_q     <= redirect_pc_i;
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                if (req_fire) begin
                    pc_q     <= next_word(pc_q);   // Drops the byte offset of a jump target
                    wr_ptr_q <= ptr_inc(wr_ptr_q);
                end
                if (head_pop_i) begin
                    rd_ptr_q <= ptr_inc(rd_ptr_q);
                end
                if (req_fire && !head_pop_i) begin
                    count_q <= count_q + 1'b1;
                end else if (!req_fire && head_pop_i) begin
                    count_q <= count_q - 1'b1;
                end
            end
        end
    end

    // The full PC is kept so the aligner can see a target with bit 1 set
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            pc_queue_q[wr_ptr_q] <= pc_q;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int ADDR_W       = 32;
    localparam int WORD_BYTES   = 4;   // Memory returns one aligned word per request
    localparam int PARCEL_BYTES = 2;

    typedef logic [ADDR_W-1:0] addr_t;

    // Aligner states
    // AL_DRAIN throws away responses that belong to a path cancelled by a redirect
    typedef enum logic [1:0] {
        AL_EMPTY = 2'd0,   // No parcel held
        AL_HALF  = 2'd1,   // Upper parcel of the last word held
        AL_DRAIN = 2'd2
    } align_state_e;

    // Address of the word that holds byte address a
    function automatic addr_t word_base(input addr_t a);
        return {a[ADDR_W-1:2], 2'b00};
    endfunction

    // Start of the word after the one that holds a
    function automatic addr_t next_word(input addr_t a);
        return word_base(a) + addr_t'(WORD_BYTES);
    endfunction

    function automatic addr_t upper_parcel(input addr_t a);
        return word_base(a) + addr_t'(PARCEL_BYTES);
    endfunction

endpackage

`default_nettype wire

//--- rtl/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
    parameter int               MAX_OUTSTANDING = 2,
    parameter fetch_pkg::addr_t RESET_PC        = 32'h0000_0000
) (
    input  wire logic             clk_i,
    input  wire logic             rstn_i,

    output logic                  mem_req_valid_o,
    output fetch_pkg::addr_t      mem_req_addr_o,
    input  wire logic             mem_req_ready_i,

    input  wire logic             mem_rsp_valid_i,
    input  wire isa_pkg::instr_t  mem_rsp_data_i,
    output logic                  mem_rsp_ready_o,

    input  wire logic             redirect_i,
    input  wire fetch_pkg::addr_t redirect_pc_i,

    input  wire logic             stall_i,
    output logic                  inst_valid_o,
    output isa_pkg::instr_t       inst_o,
    output fetch_pkg::addr_t      inst_pc_o
);

    import fetch_pkg::*;

    addr_t head_pc;      // PC of the oldest request in flight
    logic  head_valid;
    logic  head_pop;
    logic  req_fire;

    fetch_pc_gen #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING),
        .RESET_PC        (RESET_PC)
    ) u_pc_gen (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_ready_i (mem_req_ready_i),
        .req_fire_o      (req_fire),
        .head_pc_o       (head_pc),
        .head_valid_o    (head_valid),
        .head_pop_i      (head_pop)
    );

    fetch_align #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_align (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .redirect_i      (redirect_i),
        .req_fire_i      (req_fire),
        .head_pc_i       (head_pc),
        .head_valid_i    (head_valid),
        .head_pop_o      (head_pop),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .stall_i         (stall_i),
        .inst_valid_o    (inst_valid_o),
        .inst_o          (inst_o),
        .inst_pc_o       (inst_pc_o)
    );

endmodule

`default_nettype wire

//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int PARCEL_W = 16;   // One RVC parcel
    localparam int INSTR_W  = 32;   // Full instruction, also the fetch word

    typedef logic [PARCEL_W-1:0] parcel_t;
    typedef logic [INSTR_W-1:0]  instr_t;

    // The two low opcode bits of a parcel
    typedef enum logic [1:0] {
        Q0     = 2'b00,
        Q1     = 2'b01,
        Q2     = 2'b10,
        Q_FULL = 2'b11     // Start of a 32-bit instruction
    } quadrant_e;

    function automatic quadrant_e quadrant(input parcel_t p);
        return quadrant_e'(p[1:0]);
    endfunction

    function automatic logic is_compressed(input parcel_t p);
        return quadrant(p) != Q_FULL;
    endfunction

    // Decode receives compressed instructions zero-extended
    function automatic instr_t zext_parcel(input parcel_t p);
        return {{(INSTR_W - PARCEL_W){1'b0}}, p};
    endfunction

endpackage

`default_nettype wire

//--- sources.f
+incdir+tb
rtl/isa_pkg.sv
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/fetch_align.sv
rtl/fetch_top.sv
tb/tb_fetch_top.sv

//--- tb/tb_fetch_table.svh
`ifndef TB_FETCH_TABLE_SVH
`define TB_FETCH_TABLE_SVH

localparam int NUM_INSTR   = 21;
localparam int NUM_PARCELS = 32;   // The program fills 16 words from address 0
localparam int NUM_SCEN    = 6;

typedef struct packed {
    fetch_pkg::addr_t start_pc;
    logic [15:0]      redir_cycle;   // Cycle of the mid-run redirect, 0 for none
    fetch_pkg::addr_t target_pc;
    logic [31:0]      stall_seed;
    logic [15:0]      count;         // Instructions expected on the final path
} scenario_t;

// Program in address order, a value with low bits 11 takes two parcels
function automatic logic [31:0] program_instr(input int i);
    case (i)
        0:  return 32'h0000_0013;   // Four word-aligned 32-bit instructions
        1:  return 32'h0010_0093;
        2:  return 32'h0020_0113;
        3:  return 32'h0031_8193;
        4:  return 32'h0000_4501;   // Two compressed ones share a word
        5:  return 32'h0000_0505;
        6:  return 32'h0000_4585;
        7:  return 32'h00b5_0633;   // Crosses into the next word
        8:  return 32'h0000_8532;
        9:  return 32'h0020_a023;
        10: return 32'h0000_a283;
        11: return 32'h0000_0001;
        12: return 32'h4020_8233;   // Crosses a word boundary
        13: return 32'h0000_9982;
        14: return 32'h0062_8293;
        15: return 32'h0000_8082;
        16: return 32'h0000_4681;
        17: return 32'h00d5_8533;
        18: return 32'h0000_0785;
        19: return 32'h0041_0413;
        default: return 32'h0000_4701;
    endcase
endfunction

// Start, redirect cycle, target, stall seed, expected count
function automatic scenario_t scenario_row(input int i);
    case (i)
        0: return {32'h0000_0000, 16'd0, 32'h0000_0000, 32'h0000_6b1d, 16'd21};
        1: return {32'h0000_0016, 16'd0, 32'h0000_0000, 32'h0000_1f2e, 16'd14};
        2: return {32'h0000_0012, 16'd0, 32'h0000_0000, 32'h0000_2c47, 16'd16};
        3: return {32'h0000_0000, 16'd6, 32'h0000_0026, 32'h0000_3a51, 16'd9};
        4: return {32'h0000_0010, 16'd10, 32'h0000_0024, 32'h0000_4d63, 16'd10};
        default: return {32'h0000_001c, 16'd3, 32'h0000_0032, 32'h0000_5e70, 16'd5};
    endcase
endfunction

`endif

//--- tb/tb_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_top;

    import isa_pkg::*;
    import fetch_pkg::*;

    `include "tb_fetch_table.svh"

    localparam addr_t BOOT_PC = 32'h0000_0000;

    logic    clk_i = 1'b0;
    logic    rstn_i;
    logic    mem_req_valid_o;
    addr_t   mem_req_addr_o;
    logic    mem_req_ready_i;
    logic    mem_rsp_valid_i;
    instr_t  mem_rsp_data_i;
    logic    mem_rsp_ready_o;
    logic    redirect_i;
    addr_t   redirect_pc_i;
    logic    stall_i;
    logic    inst_valid_o;
    instr_t  inst_o;
    addr_t   inst_pc_o;

    parcel_t image [NUM_PARCELS];
    addr_t   req_queue [$];    // Word addresses memory still has to answer
    addr_t   exp_pc [$];
    instr_t  exp_instr [$];
    integer  mem_seed;
    integer  stall_seed;
    int      errors;
    int      checks;
    int      cyc;
    int      got;
    int      cycle_cnt;
    int      rsp_delay;
    logic    rsp_fired;
    logic    on_target;        // Expected queue holds the path the scenario ends on
    logic    done;
    logic    req_held;
    addr_t   held_addr;
    logic    out_held;
    instr_t  held_instr;
    addr_t   held_pc;

    fetch_top #(
        .MAX_OUTSTANDING (2),
        .RESET_PC        (BOOT_PC)
    ) u_dut (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .stall_i         (stall_i),
        .inst_valid_o    (inst_valid_o),
        .inst_o          (inst_o),
        .inst_pc_o       (inst_pc_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic compare_value(input string name, input logic [31:0] got_v,
                                 input logic [31:0] exp_v);
        checks++;
        if (got_v !== exp_v) begin
            errors++;
            $display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, got_v, exp_v);
        end
    endtask

    task automatic pack_program();
        logic [31:0] v;
        int          p;
        p = 0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            v = program_instr(i);
            image[p] = v[15:0];
            p++;
            if (v[1:0] == 2'b11) begin
                image[p] = v[31:16];
                p++;
            end
        end
    endtask

    // Outside the program the memory returns a pattern of the address
    function automatic instr_t memory_word(input addr_t a);
        int w;
        w = int'(a >> 2);
        if (a < addr_t'(2 * NUM_PARCELS)) begin
            return {image[2*w+1], image[2*w]};
        end
        return a ^ 32'ha5c3_0f69;
    endfunction

    // Walks the parcels from start and joins a parcel with low bits 11 to the next one
    task automatic load_path(input addr_t start);
        int p;
        exp_pc.delete();
        exp_instr.delete();
        p = int'(start >> 1);
        while (p < NUM_PARCELS) begin
            if (image[p][1:0] != 2'b11) begin
                exp_instr.push_back({16'h0000, image[p]});
                exp_pc.push_back(addr_t'(2 * p));
                p += 1;
            end else if (p + 1 < NUM_PARCELS) begin
                exp_instr.push_back({image[p+1], image[p]});
                exp_pc.push_back(addr_t'(2 * p));
                p += 2;
            end else begin
                p = NUM_PARCELS;
            end
        end
    endtask

    // Sampled at the falling edge, where all inputs and outputs are settled
    task automatic observe(input scenario_t sc);
        if (cyc == 0) begin
            compare_value("inst_valid_o", inst_valid_o, 1'b0);
            compare_value("mem_req_valid_o", mem_req_valid_o, 1'b0);
            compare_value("mem_rsp_ready_o", mem_rsp_ready_o, 1'b0);
        end
        if (req_held) begin
            compare_value("mem_req_valid_o", mem_req_valid_o, 1'b1);
            compare_value("mem_req_addr_o", mem_req_addr_o, held_addr);
        end
        if (out_held) begin   // Decode was stalled in the last cycle
            compare_value("inst_valid_o", inst_valid_o, 1'b1);
            compare_value("inst_o", inst_o, held_instr);
            compare_value("inst_pc_o", inst_pc_o, held_pc);
        end
        req_held   = mem_req_valid_o && !mem_req_ready_i && !redirect_i;
        held_addr  = mem_req_addr_o;
        out_held   = stall_i && inst_valid_o && !redirect_i;
        held_instr = inst_o;
        held_pc    = inst_pc_o;

        if (mem_req_valid_o && mem_req_ready_i) begin
            compare_value("mem_req_addr_o[1:0]", mem_req_addr_o[1:0], 2'b00);
            req_queue.push_back(mem_req_addr_o);
        end
        rsp_fired = mem_rsp_valid_i && mem_rsp_ready_o;
        if (rsp_fired) begin
            req_queue.delete(0);
        end

        if (inst_valid_o && !stall_i) begin
            if (exp_pc.size() == 0) begin
                errors++;
                $display("Decode received an unexpected instruction at %0d ns", $time);
            end else begin
                compare_value("inst_pc_o", inst_pc_o, exp_pc.pop_front());
                compare_value("inst_o", inst_o, exp_instr.pop_front());
                if (on_target) begin
                    got++;
                end
            end
        end
        if (redirect_i) begin
            load_path(redirect_pc_i);   // Old path instructions can no longer match
            on_target = (cyc != 0) || (sc.redir_cycle == 16'd0);
        end
        done = on_target && (got == int'(sc.count));
    endtask

    task automatic drive(input scenario_t sc);
        int r;
        redirect_i    = (sc.redir_cycle != 16'd0) && (cyc + 1 == int'(sc.redir_cycle));
        redirect_pc_i = sc.target_pc;
        r = $random(stall_seed);
        stall_i = (r[1:0] == 2'b00);
        r = $random(mem_seed);
        mem_req_ready_i = (r[1:0] != 2'b00);
        if (!mem_rsp_valid_i || rsp_fired) begin   // A shown response holds until taken
            mem_rsp_valid_i = 1'b0;
            if (req_queue.size() != 0) begin
                if (rsp_delay == 0) begin
                    mem_rsp_valid_i = 1'b1;
                    mem_rsp_data_i  = memory_word(req_queue[0]);
                    r = $random(mem_seed);
                    rsp_delay = int'(r[2:1]);
                end else begin
                    rsp_delay--;
                end
            end
        end
    endtask

    task automatic run_scenario(input int s);
        scenario_t sc;
        sc = scenario_row(s);
        stall_seed      = sc.stall_seed;
        rstn_i          = 1'b0;
        redirect_i      = 1'b0;
        stall_i         = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        req_queue.delete();
        exp_pc.delete();
        exp_instr.delete();
        repeat (2) @(posedge clk_i);
        #2;
        rstn_i        = 1'b1;
        redirect_i    = (sc.start_pc != BOOT_PC);   // Any other start enters like a jump target
        redirect_pc_i = sc.start_pc;
        load_path(sc.start_pc);
        cyc       = 0;
        got       = 0;
        done      = 1'b0;
        on_target = (sc.redir_cycle == 16'd0);
        req_held  = 1'b0;
        out_held  = 1'b0;
        rsp_delay = 0;
        while (!done) begin
            @(negedge clk_i);
            observe(sc);
            @(posedge clk_i);
            #2;
            drive(sc);
            cyc++;
        end
    endtask

    initial begin
        rstn_i          = 1'b0;
        redirect_i      = 1'b0;
        redirect_pc_i   = '0;
        stall_i         = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        mem_seed        = 32'h6b1d;
        errors          = 0;
        checks          = 0;
        pack_program();
        for (int s = 0; s < NUM_SCEN; s++) begin
            run_scenario(s);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        int        limit;
        scenario_t sc;
        limit = 0;
        for (int s = 0; s < NUM_SCEN; s++) begin
            sc = scenario_row(s);
            limit += 40 * int'(sc.count);
        end
        cycle_cnt = 0;
        while (cycle_cnt < limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, decode did not get all instructions", limit);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
